// ==== common/divsqrt_pkg.sv ====
/* widths, codes and flag positions shared by the integer divide/sqrt unit
   W16 operands use the low half of each word, W16 results are boxed with ones */
`default_nettype none

package divsqrt_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------
  localparam int unsigned XLEN   = 32;                // operand and result width
  localparam int unsigned HALF_W = 16;                // narrow lane
  localparam int unsigned CNT_W  = $clog2(XLEN) + 1;  // must hold XLEN itself

  // format codes
  localparam logic FMT_W32 = 1'b0;
  localparam logic FMT_W16 = 1'b1;

  // operation codes
  localparam logic OP_DIV  = 1'b0;
  localparam logic OP_SQRT = 1'b1;

  // status vector, one bit per flag
  localparam int unsigned STATUS_W = 2;
  localparam int unsigned ST_DZ    = 1;  // division by zero
  localparam int unsigned ST_NX    = 0;  // remainder left over / not a perfect square

  // one operand word, seen whole or as box over the narrow lane
  typedef union packed {
    logic [XLEN-1:0] w32;
    struct packed {
      logic [HALF_W-1:0] box;  // upper half, ignored or boxed in W16
      logic [HALF_W-1:0] h16;  // narrow lane value
    } half;
  } operand_word_u;

endpackage

`default_nettype wire

// ==== design/divsqrt_top.sv ====
/* iterative integer divide/sqrt unit with elastic input and output chains
   latency depends on format and operation, use out_valid_o and the tag to match results */
`timescale 1ns/1ps
`default_nettype none

module divsqrt_top #(
  parameter int unsigned NUM_INP_REGS = 1,
  parameter int unsigned NUM_OUT_REGS = 1,
  parameter int unsigned TAG_WIDTH    = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             flush_i,
  // request
  input  logic                             in_valid_i,
  input  logic [divsqrt_pkg::XLEN-1:0]     operand_a_i,
  input  logic [divsqrt_pkg::XLEN-1:0]     operand_b_i,
  input  logic                             fmt_i,
  input  logic                             op_i,
  input  logic [TAG_WIDTH-1:0]             tag_i,
  output logic                             in_ready_o,
  // response
  output logic                             out_valid_o,
  output logic [divsqrt_pkg::XLEN-1:0]     result_o,
  output logic [divsqrt_pkg::STATUS_W-1:0] status_o,
  output logic [TAG_WIDTH-1:0]             tag_o,
  input  logic                             out_ready_i,
  output logic                             busy_o
);

  localparam int unsigned XLEN  = divsqrt_pkg::XLEN;
  localparam int unsigned INP_W = 2 * XLEN + 2 + TAG_WIDTH;               // a, b, fmt, op, tag
  localparam int unsigned OUT_W = XLEN + divsqrt_pkg::STATUS_W + TAG_WIDTH;  // res, status, tag

  // issue side
  logic                             iss_valid;
  logic                             iss_ready;
  logic [XLEN-1:0]                  iss_a;
  logic [XLEN-1:0]                  iss_b;
  logic                             iss_fmt;
  logic                             iss_op;
  logic [TAG_WIDTH-1:0]             iss_tag;
  logic                             start;
  // latched operation and core
  logic                             start_q;
  logic [XLEN-1:0]                  lat_a;
  logic [XLEN-1:0]                  lat_b;
  logic                             lat_fmt;
  logic                             lat_op;
  logic                             core_busy;
  logic                             core_done;
  logic [XLEN-1:0]                  core_res;
  logic [divsqrt_pkg::STATUS_W-1:0] core_status;
  // result side
  logic                             res_valid;
  logic                             res_ready;
  logic [XLEN-1:0]                  res_data;
  logic [divsqrt_pkg::STATUS_W-1:0] res_status;
  logic [TAG_WIDTH-1:0]             res_tag;
  // busy sources
  logic                             inp_any;
  logic                             out_any;
  logic                             fsm_busy;

  elastic_pipe #(
    .DEPTH      (NUM_INP_REGS),
    .DATA_WIDTH (INP_W)
  ) i_inp_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .valid_i     (in_valid_i),
    .data_i      ({operand_a_i, operand_b_i, fmt_i, op_i, tag_i}),
    .ready_o     (in_ready_o),
    .valid_o     (iss_valid),
    .data_o      ({iss_a, iss_b, iss_fmt, iss_op, iss_tag}),
    .ready_i     (iss_ready),
    .any_valid_o (inp_any)
  );

  operand_latch i_operand_latch (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .start_i   (start),
    .a_i       (iss_a),
    .b_i       (iss_b),
    .fmt_i     (iss_fmt),
    .op_i      (iss_op),
    .a_o       (lat_a),
    .b_o       (lat_b),
    .fmt_o     (lat_fmt),
    .op_o      (lat_op),
    .start_q_o (start_q)
  );

  iter_divsqrt i_iter_divsqrt (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .flush_i  (flush_i),
    .start_i  (start_q),
    .a_i      (lat_a),
    .b_i      (lat_b),
    .fmt_i    (lat_fmt),
    .op_i     (lat_op),
    .busy_o   (core_busy),
    .done_o   (core_done),
    .res_o    (core_res),
    .status_o (core_status)
  );

  divsqrt_ctrl #(
    .TAG_WIDTH (TAG_WIDTH)
  ) i_divsqrt_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .issue_valid_i (iss_valid),
    .tag_i         (iss_tag),
    .issue_ready_o (iss_ready),
    .start_o       (start),
    .fmt_i         (lat_fmt),
    .core_busy_i   (core_busy),
    .core_done_i   (core_done),
    .core_res_i    (core_res),
    .core_status_i (core_status),
    .out_valid_o   (res_valid),
    .out_res_o     (res_data),
    .out_status_o  (res_status),
    .out_tag_o     (res_tag),
    .out_ready_i   (res_ready),
    .fsm_busy_o    (fsm_busy)
  );

  elastic_pipe #(
    .DEPTH      (NUM_OUT_REGS),
    .DATA_WIDTH (OUT_W)
  ) i_out_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .valid_i     (res_valid),
    .data_i      ({res_data, res_status, res_tag}),
    .ready_o     (res_ready),
    .valid_o     (out_valid_o),
    .data_o      ({result_o, status_o, tag_o}),
    .ready_i     (out_ready_i),
    .any_valid_o (out_any)
  );

  assign busy_o = inp_any | fsm_busy | out_any;  // anything in flight anywhere

endmodule

`default_nettype wire

// ==== design/elastic_pipe.sv ====
/* valid/ready register chain, DEPTH 0 connects input to output directly
   flush clears the stage valids only, stage data keeps its old value */
`timescale 1ns/1ps
`default_nettype none

module elastic_pipe #(
  parameter int unsigned DEPTH      = 1,
  parameter int unsigned DATA_WIDTH = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  // upstream side
  input  logic                  valid_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  output logic                  ready_o,
  // downstream side
  output logic                  valid_o,
  output logic [DATA_WIDTH-1:0] data_o,
  input  logic                  ready_i,
  output logic                  any_valid_o  // some stage holds an item
);

  // index i is the signal after i stages, index 0 is the chain input
  logic [DEPTH:0]        valid_q;
  logic [DEPTH:0]        ready;   // combinational, travels backwards
  logic [DATA_WIDTH-1:0] data_q [0:DEPTH];

  assign valid_q[0]   = valid_i;
  assign data_q[0]    = data_i;
  assign ready_o      = ready[0];
  assign ready[DEPTH] = ready_i;  // end of chain takes the consumer ready

  for (genvar i = 0; i < DEPTH; i++) begin : gen_stage
    logic stage_en;  // an item moves into stage i+1

    // advance when the next stage moves on or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    assign stage_en = ready[i] & valid_q[i];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i || flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];  // bubbles are squeezed out here
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_en) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  assign valid_o = valid_q[DEPTH];
  assign data_o  = data_q[DEPTH];

  // registered stages only, the chain input belongs to the producer
  always_comb begin
    any_valid_o = 1'b0;
    for (int i = 1; i <= DEPTH; i++) begin
      any_valid_o = any_valid_o | valid_q[i];
    end
  end

  // a stalled item must sit still until the consumer takes it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i && !flush_i |=> $stable(data_o))
    else $error("elastic_pipe: data_o changed while stalled");

endmodule

`default_nettype wire

// ==== divsqrt/divsqrt_ctrl.sv ====
/* issue/hold FSM between the input chain, the core and the output chain
   one operation in the core at a time, a stalled result waits in the hold register */
`timescale 1ns/1ps
`default_nettype none

module divsqrt_ctrl #(
  parameter int unsigned TAG_WIDTH = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             flush_i,
  // issue side, end of the input chain
  input  logic                             issue_valid_i,
  input  logic [TAG_WIDTH-1:0]             tag_i,
  output logic                             issue_ready_o,
  output logic                             start_o,       // operation accepted
  input  logic                             fmt_i,         // latched format
  // core
  input  logic                             core_busy_i,
  input  logic                             core_done_i,
  input  logic [divsqrt_pkg::XLEN-1:0]     core_res_i,
  input  logic [divsqrt_pkg::STATUS_W-1:0] core_status_i,
  // result side, head of the output chain
  output logic                             out_valid_o,
  output logic [divsqrt_pkg::XLEN-1:0]     out_res_o,
  output logic [divsqrt_pkg::STATUS_W-1:0] out_status_o,
  output logic [TAG_WIDTH-1:0]             out_tag_o,
  input  logic                             out_ready_i,
  output logic                             fsm_busy_o     // operation in flight
);

  localparam logic [1:0] IDLE = 2'd0;  // waiting for work
  localparam logic [1:0] BUSY = 2'd1;  // core running
  localparam logic [1:0] HOLD = 2'd2;  // result waiting for downstream

  logic [1:0]                       state_q;
  logic [1:0]                       state_d;
  logic                             unit_ready;
  logic                             hold_en;
  logic [TAG_WIDTH-1:0]             tag_q;
  logic [divsqrt_pkg::XLEN-1:0]     held_res_q;
  logic [divsqrt_pkg::STATUS_W-1:0] held_status_q;
  divsqrt_pkg::operand_word_u       res_word;

  assign unit_ready = ~core_busy_i;
  assign start_o    = issue_valid_i & issue_ready_o & ~flush_i;

  // ----------------------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------------------
  always_comb begin
    issue_ready_o = 1'b0;
    out_valid_o   = 1'b0;
    fsm_busy_o    = 1'b0;
    state_d       = state_q;
    case (state_q)
      IDLE: begin
        issue_ready_o = unit_ready;
        if (issue_valid_i && unit_ready) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        fsm_busy_o = 1'b1;
        if (core_done_i) begin
          out_valid_o = 1'b1;  // result goes out the cycle it appears
          if (out_ready_i) begin
            issue_ready_o = unit_ready;  // back to back issue
            state_d       = (issue_valid_i && unit_ready) ? BUSY : IDLE;
          end else begin
            state_d = HOLD;
          end
        end
      end
      HOLD: begin
        fsm_busy_o  = 1'b1;
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          issue_ready_o = unit_ready;
          state_d       = (issue_valid_i && unit_ready) ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    // flush wins over everything
    if (flush_i) begin
      fsm_busy_o  = 1'b0;
      out_valid_o = 1'b0;
      state_d     = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // tag rides along from issue, result parked when downstream stalls
  assign hold_en = core_done_i & ~out_ready_i;

  always_ff @(posedge clk_i) begin
    if (start_o) begin
      tag_q <= tag_i;
    end
    if (hold_en) begin
      held_res_q    <= core_res_i;
      held_status_q <= core_status_i;
    end
  end

  // ----------------------------------------------------------------------
  // output select and boxing
  // ----------------------------------------------------------------------
  always_comb begin
    res_word.w32 = (state_q == HOLD) ? held_res_q : core_res_i;  // held data first
    if (fmt_i == divsqrt_pkg::FMT_W16) begin
      res_word.half.box = '1;
    end
  end

  assign out_res_o    = res_word.w32;
  assign out_status_o = (state_q == HOLD) ? held_status_q : core_status_i;
  assign out_tag_o    = tag_q;

  // an offered result stays offered until taken or flushed
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o || flush_i)
    else $error("divsqrt_ctrl: result dropped without handshake");

endmodule

`default_nettype wire

// ==== divsqrt/iter_divsqrt.sv ====
/* radix-2 restoring divider and digit-by-digit square root, one result bit per cycle
   operands must stay stable from start to done, flush drops the operation in flight
   divide by zero gives all ones with dz, nx flags a nonzero final remainder */
`timescale 1ns/1ps
`default_nettype none

module iter_divsqrt (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             flush_i,
  input  logic                             start_i,
  input  logic [divsqrt_pkg::XLEN-1:0]     a_i,       // dividend or radicand
  input  logic [divsqrt_pkg::XLEN-1:0]     b_i,       // divisor
  input  logic                             fmt_i,
  input  logic                             op_i,
  output logic                             busy_o,
  output logic                             done_o,    // one-cycle result strobe
  output logic [divsqrt_pkg::XLEN-1:0]     res_o,
  output logic [divsqrt_pkg::STATUS_W-1:0] status_o
);

  localparam int unsigned XLEN   = divsqrt_pkg::XLEN;
  localparam int unsigned HALF_W = divsqrt_pkg::HALF_W;
  localparam int unsigned CNT_W  = divsqrt_pkg::CNT_W;
  localparam int unsigned RW     = XLEN + 2;  // partial remainder, room for the sqrt shift

  logic             running_q;   // iterations in progress
  logic             done_q;
  logic [CNT_W-1:0] cnt_q;       // iterations left
  logic [CNT_W-1:0] num_iter;
  logic [XLEN-1:0]  opnd_q;      // operand bits leave at the top, quotient enters at the bottom
  logic [XLEN-1:0]  root_q;
  logic [RW-1:0]    rem_q;
  logic [RW-1:0]    rem_shift;   // remainder with the next operand bits appended
  logic [RW-1:0]    subtrahend;
  logic [RW:0]      diff;        // msb is the borrow
  logic             bit_ok;      // trial subtraction stayed non-negative
  logic             is_div;

  assign is_div = (op_i == divsqrt_pkg::OP_DIV);

  // one result bit per cycle, sqrt eats two operand bits per root bit
  always_comb begin
    num_iter = (fmt_i == divsqrt_pkg::FMT_W32) ? CNT_W'(XLEN) : CNT_W'(HALF_W);
    if (op_i == divsqrt_pkg::OP_SQRT) begin
      num_iter = num_iter >> 1;
    end
  end

  // ----------------------------------------------------------------------
  // trial subtraction
  // ----------------------------------------------------------------------
  always_comb begin
    if (is_div) begin
      rem_shift  = {rem_q[RW-2:0], opnd_q[XLEN-1]};
      subtrahend = {2'b00, b_i};
    end else begin
      rem_shift  = {rem_q[RW-3:0], opnd_q[XLEN-1 -: 2]};
      subtrahend = {root_q, 2'b01};  // 4*root + 1
    end
    diff   = {1'b0, rem_shift} - {1'b0, subtrahend};
    bit_ok = ~diff[RW];
  end

  // iteration control, flush aborts like reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
      cnt_q     <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        running_q <= 1'b1;
        cnt_q     <= num_iter;
      end else if (running_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == CNT_W'(1)) begin
          running_q <= 1'b0;  // last bit lands on this edge
          done_q    <= 1'b1;
        end
      end
    end
  end

  // datapath registers
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rem_q  <= '0;
      root_q <= '0;
      // narrow lane moved up to the msb so it leaves first
      opnd_q <= (fmt_i == divsqrt_pkg::FMT_W16) ? a_i << HALF_W : a_i;
    end else if (running_q) begin
      rem_q <= bit_ok ? diff[RW-1:0] : rem_shift;  // restore on borrow
      if (is_div) begin
        opnd_q <= {opnd_q[XLEN-2:0], bit_ok};
      end else begin
        opnd_q <= {opnd_q[XLEN-3:0], 2'b00};
        root_q <= {root_q[XLEN-2:0], bit_ok};
      end
    end
  end

  // ----------------------------------------------------------------------
  // result and flags, valid with done_o
  // ----------------------------------------------------------------------
  assign busy_o = running_q;
  assign done_o = done_q;
  assign res_o  = is_div ? opnd_q : root_q;  // zero divisor leaves all ones here

  always_comb begin
    status_o                     = '0;
    status_o[divsqrt_pkg::ST_DZ] = is_div && (b_i == '0);
    status_o[divsqrt_pkg::ST_NX] = (rem_q != '0);
  end

  // the FSM has to wait for the previous operation to retire
  assert property (@(posedge clk_i) disable iff (!rst_n_i) start_i |-> !busy_o)
    else $error("iter_divsqrt: start while busy");

endmodule

`default_nettype wire

// ==== divsqrt/operand_latch.sv ====
/* captures one operation at issue and holds it until the next issue
   W16 operands come out zero-extended, upper input bits never reach the core */
`timescale 1ns/1ps
`default_nettype none

module operand_latch (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         start_i,    // issue pulse from the FSM
  // operation as it leaves the input chain
  input  logic [divsqrt_pkg::XLEN-1:0] a_i,
  input  logic [divsqrt_pkg::XLEN-1:0] b_i,
  input  logic                         fmt_i,
  input  logic                         op_i,
  // latched and narrowed operation
  output logic [divsqrt_pkg::XLEN-1:0] a_o,
  output logic [divsqrt_pkg::XLEN-1:0] b_o,
  output logic                         fmt_o,
  output logic                         op_o,
  output logic                         start_q_o   // core start, one cycle after issue
);

  logic [divsqrt_pkg::XLEN-1:0] a_q;
  logic [divsqrt_pkg::XLEN-1:0] b_q;
  divsqrt_pkg::operand_word_u   a_word;
  divsqrt_pkg::operand_word_u   b_word;

  // issue pulse delayed so the core sees settled operands
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      start_q_o <= 1'b0;
    end else begin
      start_q_o <= start_i;
    end
  end

  // operation registers, only written at issue
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      a_q   <= a_i;
      b_q   <= b_i;
      fmt_o <= fmt_i;
      op_o  <= op_i;
    end
  end

  // ----------------------------------------------------------------------
  // per-format narrowing
  // ----------------------------------------------------------------------
  always_comb begin
    a_word = a_q;
    b_word = b_q;
    if (fmt_o == divsqrt_pkg::FMT_W16) begin
      a_word.half.box = '0;  // keep h16, drop whatever sat above it
      b_word.half.box = '0;
    end
  end

  assign a_o = a_word.w32;
  assign b_o = b_word.w32;

endmodule

`default_nettype wire

// ==== divsqrt_top.f ====
common/divsqrt_pkg.sv
design/elastic_pipe.sv
divsqrt/operand_latch.sv
divsqrt/iter_divsqrt.sv
divsqrt/divsqrt_ctrl.sv
design/divsqrt_top.sv
sim/tb_divsqrt_top.sv

// ==== sim/tb_divsqrt_top.sv ====
/* directed tests for the divide/sqrt unit, results checked against a behavioral model
   stimulus from a 32-bit galois lfsr, one step per bit, outputs sampled on the falling edge */
`timescale 1ns/1ps
`default_nettype none

module tb_divsqrt_top;

  localparam int unsigned TAG_W    = 4;
  localparam int unsigned INP_REGS = 1;
  localparam int unsigned OUT_REGS = 1;
  localparam int MAX_LAT        = INP_REGS + 2 + 32 + OUT_REGS;  // w32 divide, no stalls
  localparam int MAX_STALL      = 32;                             // longest out_ready low stretch
  localparam int NUM_OPS        = 40;                             // upper bound over all tests
  localparam int TIMEOUT_CYCLES = 16 + NUM_OPS * (MAX_LAT + MAX_STALL + 10) + 4 * MAX_LAT + 200;
  localparam logic W32  = divsqrt_pkg::FMT_W32;
  localparam logic W16  = divsqrt_pkg::FMT_W16;
  localparam logic DIV  = divsqrt_pkg::OP_DIV;
  localparam logic SQRT = divsqrt_pkg::OP_SQRT;

  logic             clk;
  logic             rst_n;
  logic             flush;
  logic             in_valid;
  logic [31:0]      operand_a;
  logic [31:0]      operand_b;
  logic             fmt;
  logic             op;
  logic [TAG_W-1:0] in_tag;
  logic             in_ready;
  logic             out_valid;
  logic [31:0]      result;
  logic [1:0]       status;
  logic [TAG_W-1:0] out_tag;
  logic             out_ready;
  logic             busy;

  int               cycle_cnt = 0;
  logic [31:0]      lfsr_q    = 32'hae37;
  logic [TAG_W-1:0] next_tag  = '0;

  // operations waiting to be sent, with their expected responses
  logic [31:0]      send_a[$];
  logic [31:0]      send_b[$];
  logic             send_fmt[$];
  logic             send_op[$];
  logic [TAG_W-1:0] send_tag[$];
  logic [31:0]      exp_res[$];
  logic [1:0]       exp_st[$];

  divsqrt_top #(
    .NUM_INP_REGS (INP_REGS),
    .NUM_OUT_REGS (OUT_REGS),
    .TAG_WIDTH    (TAG_W)
  ) i_divsqrt_top (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .flush_i     (flush),
    .in_valid_i  (in_valid),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .fmt_i       (fmt),
    .op_i        (op),
    .tag_i       (in_tag),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .result_o    (result),
    .status_o    (status),
    .tag_o       (out_tag),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // timeout
  // ----------------------------------------------------------------------
  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout: the unit stopped responding after %0d cycles", cycle_cnt);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  // ----------------------------------------------------------------------
  // random numbers and reference model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};  // one lfsr step per bit
      lfsr_q = lfsr_step(lfsr_q);
    end
    return val;
  endfunction

  // {status, result} from the arithmetic definition
  function automatic logic [33:0] reference(input logic [31:0] a, input logic [31:0] b,
                                            input logic f, input logic o);
    logic [31:0] an;
    logic [31:0] bn;
    logic [31:0] res;
    logic [31:0] rem;
    logic [63:0] root;
    logic [63:0] trial;
    logic [1:0]  st;
    an = (f == W16) ? {16'h0000, a[15:0]} : a;  // narrow lane ignores upper bits
    bn = (f == W16) ? {16'h0000, b[15:0]} : b;
    st = '0;
    if (o == DIV) begin
      if (bn == 0) begin
        res = 32'hffff_ffff;
        rem = an;                                // dividend is left over
        st[divsqrt_pkg::ST_DZ] = 1'b1;
      end else begin
        res = an / bn;
        rem = an % bn;
      end
      st[divsqrt_pkg::ST_NX] = (rem != 0);
    end else begin
      root = 0;
      for (int i = 15; i >= 0; i--) begin
        trial = root | (64'd1 << i);
        if (trial * trial <= an) root = trial;  // largest root with root^2 <= an
      end
      res = root[31:0];
      st[divsqrt_pkg::ST_NX] = (root * root != an);
    end
    if (f == W16) res[31:16] = 16'hffff;       // boxing
    return {st, res};
  endfunction

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic add_op(input logic [31:0] a, input logic [31:0] b, input logic f,
                        input logic o);
    logic [33:0] ref_val;
    ref_val = reference(a, b, f, o);
    send_a.push_back(a);
    send_b.push_back(b);
    send_fmt.push_back(f);
    send_op.push_back(o);
    send_tag.push_back(next_tag);
    exp_res.push_back(ref_val[31:0]);
    exp_st.push_back(ref_val[33:32]);
    next_tag = next_tag + 1'b1;
  endtask

  // feeds the queued operations and checks every response in order
  task automatic run_queued(input logic backpressure);
    int sent;
    int recv;
    int stall;
    sent  = 0;
    recv  = 0;
    stall = 0;
    while (recv < send_a.size()) begin
      @(posedge clk);
      if (sent < send_a.size()) begin
        in_valid  <= 1'b1;
        operand_a <= send_a[sent];
        operand_b <= send_b[sent];
        fmt       <= send_fmt[sent];
        op        <= send_op[sent];
        in_tag    <= send_tag[sent];
      end else begin
        in_valid <= 1'b0;
      end
      if (stall > 0) begin
        out_ready <= 1'b0;  // downstream stalled
        stall--;
      end else begin
        out_ready <= 1'b1;
        // long stretches keep the output stage full until the next done, forcing HOLD
        if (backpressure && rand_bits(2) == 0) stall = 1 + rand_bits(5);
      end
      @(negedge clk);
      if (in_valid && in_ready) sent++;  // taken on the next rising edge
      if (out_valid && out_ready) begin
        check_value("result_o", result, exp_res[recv]);
        check_value("status_o", status, exp_st[recv]);
        check_value("tag_o", out_tag, send_tag[recv]);
        recv++;
      end
    end
    @(posedge clk);
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    send_a.delete();
    send_b.delete();
    send_fmt.delete();
    send_op.delete();
    send_tag.delete();
    exp_res.delete();
    exp_st.delete();
  endtask

  // single transfer, result not collected
  task automatic send_one(input logic [31:0] a, input logic [31:0] b, input logic f,
                          input logic o);
    @(posedge clk);
    in_valid  <= 1'b1;
    operand_a <= a;
    operand_b <= b;
    fmt       <= f;
    op        <= o;
    in_tag    <= next_tag;
    next_tag = next_tag + 1'b1;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic test_reset();
    @(negedge clk);
    check_value("out_valid_o", out_valid, 1'b0);
    check_value("busy_o", busy, 1'b0);
    check_value("in_ready_o", in_ready, 1'b1);
  endtask

  task automatic test_divide();
    logic [31:0] b;
    logic [31:0] bl;
    for (int i = 0; i < 4; i++) begin
      b = rand_bits(16) >> rand_bits(4);  // spread the quotient sizes
      add_op(rand_bits(32), b, W32, DIV);
      b = (rand_bits(16) << 16) | rand_bits(8);  // junk above the narrow lane
      add_op(rand_bits(32), b, W16, DIV);
    end
    b = rand_bits(12) | 32'd1;
    add_op(b * rand_bits(16), b, W32, DIV);  // exact, no nx
    bl = rand_bits(6) | 32'd1;
    add_op((rand_bits(16) << 16) | (bl * rand_bits(8)), (rand_bits(16) << 16) | bl, W16, DIV);
    run_queued(1'b0);
  endtask

  task automatic test_special();
    add_op(rand_bits(32), 32'h0000_0000, W32, DIV);
    add_op(rand_bits(32), 32'habcd_0000, W16, DIV);  // narrow divisor is zero
    add_op(32'd0, 32'd0, W32, SQRT);
    add_op(32'd1522756, 32'd0, W32, SQRT);           // 1234 squared
    add_op(32'hfffe_0001, 32'd0, W32, SQRT);         // 65535 squared
    add_op(32'hffff_ffff, 32'd0, W32, SQRT);
    add_op(rand_bits(32), rand_bits(32), W32, SQRT);
    add_op(32'h1234_0090, 32'd0, W16, SQRT);         // 144 in the narrow lane
    add_op(32'h0000_ffff, 32'd0, W16, SQRT);
    add_op(rand_bits(32), rand_bits(32), W16, SQRT);
    run_queued(1'b0);
  endtask

  task automatic test_backpressure();
    logic f;
    logic o;
    for (int i = 0; i < 12; i++) begin
      f = rand_bits(1);
      o = rand_bits(1);
      add_op(rand_bits(32), rand_bits(32) >> rand_bits(5), f, o);
    end
    run_queued(1'b1);
  endtask

  task automatic test_flush();
    send_one(32'hfedc_ba98, 32'd7, W32, DIV);
    send_one(32'h0123_4567, 32'd9, W32, DIV);
    // first in the core, second parked in the input chain
    repeat (8) begin
      @(negedge clk);
      check_value("out_valid_o", out_valid, 1'b0);
      check_value("busy_o", busy, 1'b1);
    end
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    check_value("busy_o", busy, 1'b0);
    repeat (2 * MAX_LAT) begin
      @(negedge clk);
      check_value("out_valid_o", out_valid, 1'b0);  // nothing flushed may come out
    end
    add_op(32'd1000, 32'd7, W32, DIV);
    run_queued(1'b0);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    rst_n     = 1'b0;
    flush     = 1'b0;
    in_valid  = 1'b0;
    operand_a = '0;
    operand_b = '0;
    fmt       = W32;
    op        = DIV;
    in_tag    = '0;
    out_ready = 1'b1;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_divide();
    test_special();
    test_backpressure();
    test_flush();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
